// ==== filelist.f ====
+incdir+verif
hw/id_pkg.sv
hw/if_id_reg.sv
hw/instr_decoder.sv
hw/imm_target_gen.sv
hw/reg_file.sv
hw/id_stage.sv
verif/id_stage_tb.sv

// ==== hw/id_pkg.sv ====
package id_pkg;

    //////////////////////////////
    // Widths and field positions
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    //////////////////////////////
    // Encodings
    //////////////////////////////
    typedef enum logic [OPCODE_W-1:0] {
        OPCODE_LOAD   = 7'b000_0011,
        OPCODE_OPIMM  = 7'b001_0011,
        OPCODE_AUIPC  = 7'b001_0111,
        OPCODE_STORE  = 7'b010_0011,
        OPCODE_OP     = 7'b011_0011,
        OPCODE_LUI    = 7'b011_0111,
        OPCODE_BRANCH = 7'b110_0011,
        OPCODE_JALR   = 7'b110_0111,
        OPCODE_JAL    = 7'b110_1111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_AND  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10  // Pass immediate through
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG = 2'd0,
        ALU_SRC_PC  = 2'd1,
        ALU_SRC_IMM = 2'd2
    } alu_src_e;

    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_MEM    = 2'd1,
        WB_PCINCR = 2'd2
    } wb_sel_e;

    // Conditional branches are {1'b0, funct3}
    typedef enum logic [3:0] {
        BRCH_BEQ  = 4'b0000,
        BRCH_BNE  = 4'b0001,
        BRCH_BLT  = 4'b0100,
        BRCH_BGE  = 4'b0101,
        BRCH_BLTU = 4'b0110,
        BRCH_BGEU = 4'b0111,
        BRCH_NOP  = 4'b1000,
        BRCH_JALR = 4'b1001
    } branch_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_IZ   = 3'd1,
        IMM_S    = 3'd2,
        IMM_SB   = 3'd3,
        IMM_U    = 3'd4,
        IMM_UJ   = 3'd5,
        IMM_FOUR = 3'd6
    } imm_sel_e;

    // Same values as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B    = 3'b000,
        MEM_H    = 3'b001,
        MEM_W    = 3'b010,
        MEM_BU   = 3'b100,
        MEM_HU   = 3'b101,
        MEM_NONE = 3'b111  // No access
    } mem_type_e;

endpackage

// ==== hw/id_stage.sv ====
module id_stage #(
    parameter int DATA_WIDTH = id_pkg::XLEN,
    parameter int ADDR_WIDTH = id_pkg::REG_ADDR_W
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    stall_i,
    input  logic                    clear_i,
    input  logic [id_pkg::XLEN-1:0] instr_i,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  logic                    wb_we_i,
    input  logic [ADDR_WIDTH-1:0]   wb_waddr_i,
    input  logic [DATA_WIDTH-1:0]   wb_wdata_i,
    output logic [id_pkg::XLEN-1:0] pc_o,
    output logic                    jump_o,
    output logic [id_pkg::XLEN-1:0] jump_target_o,
    output logic                    illegal_o,
    output logic                    alu_en_o,
    output id_pkg::alu_op_e         alu_op_o,
    output id_pkg::alu_src_e        alu_src_1_o,
    output id_pkg::alu_src_e        alu_src_2_o,
    output logic [ADDR_WIDTH-1:0]   rs1_addr_o,
    output logic [ADDR_WIDTH-1:0]   rs2_addr_o,
    output logic [DATA_WIDTH-1:0]   rs1_data_o,
    output logic [DATA_WIDTH-1:0]   rs2_data_o,
    output logic                    rs1_used_o,
    output logic                    rs2_used_o,
    output logic [id_pkg::XLEN-1:0] imm_o,
    output logic [ADDR_WIDTH-1:0]   rd_addr_o,
    output logic                    regfile_we_o,
    output id_pkg::wb_sel_e         wb_sel_o,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output id_pkg::mem_type_e       mem_type_o,
    output id_pkg::branch_e         branch_o
);

    logic [id_pkg::XLEN-1:0] instr_id;
    logic [id_pkg::XLEN-1:0] pc_id;
    id_pkg::imm_sel_e        imm_sel;

    assign pc_o = pc_id;

    //////////////////////////////
    // Pipeline register
    //////////////////////////////
    if_id_reg u_if_id_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .clear_i  (clear_i),
        .instr_i  (instr_i),
        .pc_i     (pc_i),
        .instr_o  (instr_id),
        .pc_o     (pc_id)
    );

    //////////////////////////////
    // Decode and operands
    //////////////////////////////
    instr_decoder u_instr_decoder (
        .clk          (clk),
        .instr_i      (instr_id),
        .jump_o       (jump_o),
        .alu_en_o     (alu_en_o),
        .alu_op_o     (alu_op_o),
        .alu_src_1_o  (alu_src_1_o),
        .alu_src_2_o  (alu_src_2_o),
        .rs1_used_o   (rs1_used_o),
        .rs2_used_o   (rs2_used_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_type_o   (mem_type_o),
        .regfile_we_o (regfile_we_o),
        .wb_sel_o     (wb_sel_o),
        .branch_o     (branch_o),
        .imm_sel_o    (imm_sel),
        .illegal_o    (illegal_o)
    );

    imm_target_gen u_imm_target_gen (
        .instr_i       (instr_id),
        .pc_i          (pc_id),
        .imm_sel_i     (imm_sel),
        .imm_o         (imm_o),
        .jump_target_o (jump_target_o)
    );

    // Write-back port comes straight from the later stage
    reg_file #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .instr_i    (instr_id),
        .we_i       (wb_we_i),
        .waddr_i    (wb_waddr_i),
        .wdata_i    (wb_wdata_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr_o),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

// ==== hw/if_id_reg.sv ====
module if_id_reg (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    stall_i,
    input  logic                    clear_i,
    input  logic [id_pkg::XLEN-1:0] instr_i,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    output logic [id_pkg::XLEN-1:0] instr_o,
    output logic [id_pkg::XLEN-1:0] pc_o
);

    // Stall wins over clear, clear wins over load
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_o <= id_pkg::NOP_INSTR;
            pc_o    <= '0;
        end else if (stall_i) begin
            instr_o <= instr_o;  // Hold
            pc_o    <= pc_o;
        end else if (clear_i) begin
            instr_o <= id_pkg::NOP_INSTR;  // Bubble
            pc_o    <= '0;
        end else begin
            instr_o <= instr_i;
            pc_o    <= pc_i;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Held contents survive a stall edge
    a_stall_holds : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        stall_i |=> ($stable(instr_o) && $stable(pc_o))
    ) else $error("IF/ID contents changed across a stall");

endmodule

// ==== hw/imm_target_gen.sv ====
module imm_target_gen (
    input  logic [id_pkg::XLEN-1:0] instr_i,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  id_pkg::imm_sel_e        imm_sel_i,
    output logic [id_pkg::XLEN-1:0] imm_o,
    output logic [id_pkg::XLEN-1:0] jump_target_o
);

    logic [id_pkg::XLEN-1:0] imm_i;
    logic [id_pkg::XLEN-1:0] imm_iz;
    logic [id_pkg::XLEN-1:0] imm_s;
    logic [id_pkg::XLEN-1:0] imm_sb;
    logic [id_pkg::XLEN-1:0] imm_u;
    logic [id_pkg::XLEN-1:0] imm_uj;

    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_iz = {20'b0, instr_i[31:20]};                      // Zero extended
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u  = {instr_i[31:12], 12'b0};
    assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                     instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (imm_sel_i)
            id_pkg::IMM_I:    imm_o = imm_i;
            id_pkg::IMM_IZ:   imm_o = imm_iz;
            id_pkg::IMM_S:    imm_o = imm_s;
            id_pkg::IMM_SB:   imm_o = imm_sb;
            id_pkg::IMM_U:    imm_o = imm_u;
            id_pkg::IMM_UJ:   imm_o = imm_uj;
            id_pkg::IMM_FOUR: imm_o = id_pkg::XLEN'(4);  // Link offset
            default:          imm_o = '0;
        endcase
    end

    // JAL target is always ready, used only when jump_o is high
    assign jump_target_o = pc_i + imm_uj;

endmodule

// ==== hw/instr_decoder.sv ====
module instr_decoder (
    input  logic                    clk,
    input  logic [id_pkg::XLEN-1:0] instr_i,
    output logic                    jump_o,
    output logic                    alu_en_o,
    output id_pkg::alu_op_e         alu_op_o,
    output id_pkg::alu_src_e        alu_src_1_o,
    output id_pkg::alu_src_e        alu_src_2_o,
    output logic                    rs1_used_o,
    output logic                    rs2_used_o,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output id_pkg::mem_type_e       mem_type_o,
    output logic                    regfile_we_o,
    output id_pkg::wb_sel_e         wb_sel_o,
    output id_pkg::branch_e         branch_o,
    output id_pkg::imm_sel_e        imm_sel_o,
    output logic                    illegal_o
);

    id_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    assign opcode = id_pkg::opcode_e'(instr_i[id_pkg::OPCODE_W-1:0]);
    assign funct3 = instr_i[id_pkg::FUNCT3_LSB +: 3];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Defaults describe a harmless bubble
        jump_o       = 1'b0;
        alu_en_o     = 1'b0;
        alu_op_o     = id_pkg::ALU_ADD;
        alu_src_1_o  = id_pkg::ALU_SRC_REG;
        alu_src_2_o  = id_pkg::ALU_SRC_REG;
        rs1_used_o   = 1'b0;
        rs2_used_o   = 1'b0;
        mem_req_o    = 1'b0;
        mem_we_o     = 1'b0;
        mem_type_o   = id_pkg::MEM_NONE;
        regfile_we_o = 1'b0;
        wb_sel_o     = id_pkg::WB_ALU;
        branch_o     = id_pkg::BRCH_NOP;
        imm_sel_o    = id_pkg::IMM_I;
        illegal_o    = 1'b0;

        case (opcode)
            id_pkg::OPCODE_JAL: begin
                // ALU forms the link value pc + 4
                jump_o       = 1'b1;
                alu_en_o     = 1'b1;
                alu_src_1_o  = id_pkg::ALU_SRC_PC;
                alu_src_2_o  = id_pkg::ALU_SRC_IMM;
                regfile_we_o = 1'b1;
                imm_sel_o    = id_pkg::IMM_FOUR;
            end
            id_pkg::OPCODE_JALR: begin
                alu_en_o     = 1'b1;
                alu_src_2_o  = id_pkg::ALU_SRC_IMM;  // Target rs1 + imm
                rs1_used_o   = 1'b1;
                regfile_we_o = 1'b1;
                wb_sel_o     = id_pkg::WB_PCINCR;
                branch_o     = id_pkg::BRCH_JALR;
            end
            id_pkg::OPCODE_BRANCH: begin
                alu_en_o    = 1'b1;
                alu_src_1_o = id_pkg::ALU_SRC_PC;
                alu_src_2_o = id_pkg::ALU_SRC_IMM;
                rs1_used_o  = 1'b1;
                rs2_used_o  = 1'b1;
                branch_o    = id_pkg::branch_e'({1'b0, funct3});
                imm_sel_o   = id_pkg::IMM_SB;
            end
            id_pkg::OPCODE_STORE: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = id_pkg::ALU_SRC_IMM;
                rs1_used_o  = 1'b1;
                rs2_used_o  = 1'b1;
                imm_sel_o   = id_pkg::IMM_S;
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin  // SB, SH, SW
                    mem_req_o  = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_type_o = id_pkg::mem_type_e'(funct3);
                end else begin
                    illegal_o = 1'b1;
                end
            end
            id_pkg::OPCODE_LOAD: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = id_pkg::ALU_SRC_IMM;
                rs1_used_o  = 1'b1;
                wb_sel_o    = id_pkg::WB_MEM;
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    mem_req_o    = 1'b1;
                    regfile_we_o = 1'b1;
                    mem_type_o   = id_pkg::mem_type_e'(funct3);
                end else begin
                    illegal_o = 1'b1;
                end
            end
            id_pkg::OPCODE_LUI: begin
                alu_en_o     = 1'b1;
                alu_op_o     = id_pkg::ALU_LUI;
                alu_src_2_o  = id_pkg::ALU_SRC_IMM;
                regfile_we_o = 1'b1;
                imm_sel_o    = id_pkg::IMM_U;
            end
            id_pkg::OPCODE_AUIPC: begin
                alu_en_o     = 1'b1;
                alu_src_1_o  = id_pkg::ALU_SRC_PC;
                alu_src_2_o  = id_pkg::ALU_SRC_IMM;
                regfile_we_o = 1'b1;
                imm_sel_o    = id_pkg::IMM_U;
            end
            id_pkg::OPCODE_OPIMM: begin
                alu_en_o     = 1'b1;
                alu_src_2_o  = id_pkg::ALU_SRC_IMM;
                rs1_used_o   = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = id_pkg::ALU_ADD;
                    3'b010: alu_op_o = id_pkg::ALU_SLT;
                    3'b011: alu_op_o = id_pkg::ALU_SLTU;
                    3'b100: alu_op_o = id_pkg::ALU_XOR;
                    3'b110: alu_op_o = id_pkg::ALU_OR;
                    3'b001: begin
                        if (funct7 == 7'b000_0000)  // Shamt only
                            alu_op_o = id_pkg::ALU_SLL;
                        else
                            illegal_o = 1'b1;
                    end
                    3'b101: begin
                        if (funct7 == 7'b000_0000)
                            alu_op_o = id_pkg::ALU_SRL;
                        else if (funct7 == 7'b010_0000)
                            alu_op_o = id_pkg::ALU_SRA;
                        else
                            illegal_o = 1'b1;
                    end
                    default: alu_op_o = id_pkg::ALU_AND;  // 3'b111
                endcase
                regfile_we_o = !illegal_o;  // No write-back for a bad shift
            end
            id_pkg::OPCODE_OP: begin
                alu_en_o     = 1'b1;
                rs1_used_o   = 1'b1;
                rs2_used_o   = 1'b1;
                case ({funct7, funct3})
                    {7'b000_0000, 3'b000}: alu_op_o = id_pkg::ALU_ADD;
                    {7'b010_0000, 3'b000}: alu_op_o = id_pkg::ALU_SUB;
                    {7'b000_0000, 3'b010}: alu_op_o = id_pkg::ALU_SLT;
                    {7'b000_0000, 3'b011}: alu_op_o = id_pkg::ALU_SLTU;
                    {7'b000_0000, 3'b100}: alu_op_o = id_pkg::ALU_XOR;
                    {7'b000_0000, 3'b110}: alu_op_o = id_pkg::ALU_OR;
                    {7'b000_0000, 3'b111}: alu_op_o = id_pkg::ALU_AND;
                    {7'b000_0000, 3'b001}: alu_op_o = id_pkg::ALU_SLL;
                    {7'b000_0000, 3'b101}: alu_op_o = id_pkg::ALU_SRL;
                    {7'b010_0000, 3'b101}: alu_op_o = id_pkg::ALU_SRA;
                    default:               illegal_o = 1'b1;
                endcase
                regfile_we_o = !illegal_o;
            end
            default: illegal_o = 1'b1;  // Unknown major opcode
        endcase
    end

    // An illegal instruction must not change architectural state
    a_illegal_quiet : assert property (
        @(posedge clk) illegal_o |-> !(regfile_we_o || mem_req_o || jump_o)
    ) else $error("Illegal instruction left a side effect enabled");

endmodule

// ==== hw/reg_file.sv ====
module reg_file #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [id_pkg::XLEN-1:0] instr_i,
    input  logic                    we_i,
    input  logic [ADDR_WIDTH-1:0]   waddr_i,
    input  logic [DATA_WIDTH-1:0]   wdata_i,
    output logic [ADDR_WIDTH-1:0]   rs1_addr_o,
    output logic [ADDR_WIDTH-1:0]   rs2_addr_o,
    output logic [ADDR_WIDTH-1:0]   rd_addr_o,
    output logic [DATA_WIDTH-1:0]   rs1_data_o,
    output logic [DATA_WIDTH-1:0]   rs2_data_o
);

    localparam int NUM_REGS = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    assign rs1_addr_o = instr_i[id_pkg::RS1_LSB +: ADDR_WIDTH];
    assign rs2_addr_o = instr_i[id_pkg::RS2_LSB +: ADDR_WIDTH];
    assign rd_addr_o  = instr_i[id_pkg::RD_LSB +: ADDR_WIDTH];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write-back bypass
    assign rs1_data_o = (we_i && (waddr_i == rs1_addr_o) && (rs1_addr_o != '0)) ?
                        wdata_i : regs[rs1_addr_o];
    assign rs2_data_o = (we_i && (waddr_i == rs2_addr_o) && (rs2_addr_o != '0)) ?
                        wdata_i : regs[rs2_addr_o];

    a_x0_reads_zero : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (rs1_addr_o == '0) |-> (rs1_data_o == '0)
    ) else $error("x0 read returned a nonzero value");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module id_stage_tb -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/id_stage_ref.svh ====
`ifndef ID_STAGE_REF_SVH
`define ID_STAGE_REF_SVH

// Expected values of every decode output for one instruction
typedef struct packed {
    logic        jump;
    logic        alu_en;
    logic [3:0]  alu_op;
    logic [1:0]  alu_src_1;
    logic [1:0]  alu_src_2;
    logic        rs1_used;
    logic        rs2_used;
    logic        mem_req;
    logic        mem_we;
    logic [2:0]  mem_type;
    logic        regfile_we;
    logic [1:0]  wb_sel;
    logic [3:0]  branch;
    logic [31:0] imm;
    logic [31:0] jump_target;
    logic        illegal;
} decode_exp_t;

function automatic decode_exp_t ref_decode(input logic [31:0] instr, input logic [31:0] pc);
    decode_exp_t e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_sb;
    logic [31:0] imm_u;
    logic [31:0] imm_uj;
    f3     = instr[14:12];
    f7     = instr[31:25];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_sb = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u  = {instr[31:12], 12'h000};
    imm_uj = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    e             = '0;  // ADD, register sources, ALU write-back
    e.mem_type    = id_pkg::MEM_NONE;
    e.branch      = id_pkg::BRCH_NOP;
    e.imm         = imm_i;
    e.jump_target = pc + imm_uj;
    case (instr[6:0])
        7'h6F: begin  // JAL links through the ALU as pc + 4
            {e.jump, e.alu_en, e.regfile_we} = 3'b111;
            e.alu_src_1 = id_pkg::ALU_SRC_PC;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.imm       = 32'd4;
        end
        7'h67: begin
            {e.alu_en, e.rs1_used, e.regfile_we} = 3'b111;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.wb_sel    = id_pkg::WB_PCINCR;
            e.branch    = id_pkg::BRCH_JALR;
        end
        7'h63: begin
            {e.alu_en, e.rs1_used, e.rs2_used} = 3'b111;
            e.alu_src_1 = id_pkg::ALU_SRC_PC;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.branch    = {1'b0, f3};
            e.imm       = imm_sb;
        end
        7'h23: begin
            {e.alu_en, e.rs1_used, e.rs2_used, e.mem_req, e.mem_we} = 5'b11111;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.imm       = imm_s;
            if (f3 <= 3'd2) e.mem_type = f3;
            else            e.illegal  = 1'b1;
        end
        7'h03: begin
            {e.alu_en, e.rs1_used, e.mem_req, e.regfile_we} = 4'b1111;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.wb_sel    = id_pkg::WB_MEM;
            if (f3 == 3'd3 || f3 >= 3'd6) e.illegal  = 1'b1;
            else                          e.mem_type = f3;
        end
        7'h37, 7'h17: begin
            {e.alu_en, e.regfile_we} = 2'b11;
            e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            e.imm       = imm_u;
            if (instr[5]) e.alu_op    = id_pkg::ALU_LUI;
            else          e.alu_src_1 = id_pkg::ALU_SRC_PC;  // AUIPC
        end
        7'h13, 7'h33: begin
            {e.alu_en, e.rs1_used, e.regfile_we} = 3'b111;
            e.rs2_used = instr[5];
            if (!instr[5]) e.alu_src_2 = id_pkg::ALU_SRC_IMM;
            // Only shifts and SUB may set funct7, SUB only in OP
            if (instr[5] || f3 == 3'd1 || f3 == 3'd5) begin
                if (f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && instr[5])))
                    e.alu_op = (f3 == 3'd5) ? id_pkg::ALU_SRA : id_pkg::ALU_SUB;
                else if (f7 != 7'h00)
                    e.illegal = 1'b1;
            end
            if (e.alu_op == id_pkg::ALU_ADD) begin
                case (f3)
                    3'd1: e.alu_op = id_pkg::ALU_SLL;
                    3'd2: e.alu_op = id_pkg::ALU_SLT;
                    3'd3: e.alu_op = id_pkg::ALU_SLTU;
                    3'd4: e.alu_op = id_pkg::ALU_XOR;
                    3'd5: e.alu_op = id_pkg::ALU_SRL;
                    3'd6: e.alu_op = id_pkg::ALU_OR;
                    3'd7: e.alu_op = id_pkg::ALU_AND;
                    default: e.alu_op = id_pkg::ALU_ADD;
                endcase
            end
            if (e.illegal) e.alu_op = id_pkg::ALU_ADD;
        end
        default: e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
        {e.jump, e.mem_req, e.mem_we, e.regfile_we} = 4'b0000;
    end
    return e;
endfunction

`endif

// ==== verif/id_stage_tb.sv ====
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "id_stage_ref.svh"

    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] LD_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    localparam logic [9:0] OP_F73 [10] = '{
        {7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2}, {7'h00, 3'd3},
        {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5}, {7'h00, 3'd6}, {7'h00, 3'd7}
    };

    logic        clk;
    logic        arst_n_i;
    logic        stall_i;
    logic        clear_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        wb_we_i;
    logic [4:0]  wb_waddr_i;
    logic [31:0] wb_wdata_i;
    logic [31:0] pc_o;
    logic        jump_o;
    logic [31:0] jump_target_o;
    logic        illegal_o;
    logic        alu_en_o;
    id_pkg::alu_op_e   alu_op_o;
    id_pkg::alu_src_e  alu_src_1_o;
    id_pkg::alu_src_e  alu_src_2_o;
    logic [4:0]  rs1_addr_o;
    logic [4:0]  rs2_addr_o;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic        rs1_used_o;
    logic        rs2_used_o;
    logic [31:0] imm_o;
    logic [4:0]  rd_addr_o;
    logic        regfile_we_o;
    id_pkg::wb_sel_e   wb_sel_o;
    logic        mem_req_o;
    logic        mem_we_o;
    id_pkg::mem_type_e mem_type_o;
    id_pkg::branch_e   branch_o;

    integer      seed;
    int          errors;
    int          checks;
    int          test_errors;
    string       cur_test;
    logic [31:0] shadow [32];

    id_stage #(.DATA_WIDTH(32), .ADDR_WIDTH(5)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 5 cycles, released on a falling edge
    initial begin
        arst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
    end

    // Mirror of every write-back that the testbench drives
    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_we_i && wb_waddr_i != 5'd0) begin
            shadow[wb_waddr_i] <= wb_wdata_i;
        end
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", cur_test, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: finished with %0d mismatches", cur_test, test_errors);
    endtask

    // Called on a falling edge, returns on the falling edge after capture
    task automatic apply(input logic [31:0] instr, input logic [31:0] pc);
        instr_i = instr;
        pc_i    = pc;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic compare_outputs(input logic [31:0] instr, input logic [31:0] pc);
        decode_exp_t e;
        e = ref_decode(instr, pc);
        check_val("pc_o", pc, pc_o);
        check_val("jump_o", 32'(e.jump), 32'(jump_o));
        check_val("alu_en_o", 32'(e.alu_en), 32'(alu_en_o));
        check_val("alu_op_o", 32'(e.alu_op), 32'(alu_op_o));
        check_val("alu_src_1_o", 32'(e.alu_src_1), 32'(alu_src_1_o));
        check_val("alu_src_2_o", 32'(e.alu_src_2), 32'(alu_src_2_o));
        check_val("rs1_used_o", 32'(e.rs1_used), 32'(rs1_used_o));
        check_val("rs2_used_o", 32'(e.rs2_used), 32'(rs2_used_o));
        check_val("mem_req_o", 32'(e.mem_req), 32'(mem_req_o));
        check_val("mem_we_o", 32'(e.mem_we), 32'(mem_we_o));
        check_val("mem_type_o", 32'(e.mem_type), 32'(mem_type_o));
        check_val("regfile_we_o", 32'(e.regfile_we), 32'(regfile_we_o));
        check_val("wb_sel_o", 32'(e.wb_sel), 32'(wb_sel_o));
        check_val("branch_o", 32'(e.branch), 32'(branch_o));
        check_val("imm_o", e.imm, imm_o);
        check_val("jump_target_o", e.jump_target, jump_target_o);
        check_val("illegal_o", 32'(e.illegal), 32'(illegal_o));
        check_val("rs1_addr_o", 32'(instr[19:15]), 32'(rs1_addr_o));
        check_val("rs2_addr_o", 32'(instr[24:20]), 32'(rs2_addr_o));
        check_val("rd_addr_o", 32'(instr[11:7]), 32'(rd_addr_o));
    endtask

    task automatic gen_legal(input int cls, output logic [31:0] instr);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [9:0]  f73;
        r = $random(seed);
        s = $random(seed);
        case (cls)
            0: instr = {r[31:7], 7'h37};
            1: instr = {r[31:7], 7'h17};
            2: instr = {r[31:7], 7'h6F};
            3: instr = {r[31:15], 3'd0, r[11:7], 7'h67};
            4: instr = {r[31:15], BR_F3[int'(s[15:0] % 16'd6)], r[11:7], 7'h63};
            5: instr = {r[31:15], LD_F3[int'(s[15:0] % 16'd5)], r[11:7], 7'h03};
            6: instr = {r[31:15], 3'(s[15:0] % 16'd3), r[11:7], 7'h23};
            7: begin
                f3 = s[2:0];
                f7 = r[31:25];
                if (f3 == 3'd1) f7 = 7'h00;
                if (f3 == 3'd5) f7 = s[3] ? 7'h20 : 7'h00;
                instr = {f7, r[24:15], f3, r[11:7], 7'h13};
            end
            default: begin
                f73   = OP_F73[int'(s[15:0] % 16'd10)];
                instr = {f73[9:3], r[24:15], f73[2:0], r[11:7], 7'h33};
            end
        endcase
    endtask

    task automatic check_quiet(input logic [31:0] instr);
        apply(instr, 32'h0000_0100);
        compare_outputs(instr, 32'h0000_0100);
        check_val("illegal_o high", 32'd1, 32'(illegal_o));
        check_val("quiet regfile_we_o", 32'd0, 32'(regfile_we_o));
        check_val("quiet mem_req_o", 32'd0, 32'(mem_req_o));
        check_val("quiet jump_o", 32'd0, 32'(jump_o));
    endtask

    initial begin
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] held;
        logic [31:0] val;
        int          wait_cnt;
        seed = 32'h3170;
        errors = 0;
        checks = 0;
        stall_i = 1'b0;
        clear_i = 1'b0;
        instr_i = id_pkg::NOP_INSTR;
        pc_i = '0;
        wb_we_i = 1'b0;
        wb_waddr_i = '0;
        wb_wdata_i = '0;

        wait_cnt = 0;
        while (arst_n_i !== 1'b1) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 50) begin
                $display("Reset was not released within 50 cycles");
                $display("Checks failed");
                $finish;
            end
        end

        begin_test("after_reset");
        check_val("jump_o", 32'd0, 32'(jump_o));
        check_val("mem_req_o", 32'd0, 32'(mem_req_o));
        check_val("illegal_o", 32'd0, 32'(illegal_o));
        check_val("rs1_data_o", 32'd0, rs1_data_o);
        check_val("rs2_data_o", 32'd0, rs2_data_o);
        end_test();

        begin_test("random_legal");
        for (int i = 0; i < 270; i++) begin
            gen_legal(i % 9, instr);
            pc = $random(seed);
            pc[1:0] = 2'b00;
            apply(instr, pc);
            compare_outputs(instr, pc);
            check_val("illegal_o low", 32'd0, 32'(illegal_o));
        end
        end_test();

        begin_test("illegal");
        check_quiet(32'h0000_007F);                               // Unknown opcode
        check_quiet({12'h010, 5'd1, 3'd3, 5'd2, 7'h03});           // Load funct3 3
        check_quiet({7'h00, 5'd3, 5'd1, 3'd4, 5'd8, 7'h23});       // Store funct3 4
        check_quiet({7'h01, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33});       // OP funct7 1
        end_test();

        begin_test("reg_file");
        for (int i = 0; i < 60; i++) begin
            gen_legal(8, instr);
            wb_we_i    = 1'b1;
            wb_waddr_i = (i % 7 == 0) ? 5'd0 : 5'($random(seed));
            wb_wdata_i = $random(seed);
            apply(instr, 32'h0000_0200);
            check_val("rs1_data_o", shadow[instr[19:15]], rs1_data_o);
            check_val("rs2_data_o", shadow[instr[24:20]], rs2_data_o);
        end
        wb_we_i    = 1'b1;
        wb_waddr_i = 5'd0;
        wb_wdata_i = 32'hDEAD_BEEF;
        apply({7'h00, 5'd0, 5'd0, 3'd0, 5'd1, 7'h33}, 32'h0000_0204);
        check_val("x0 read", 32'd0, rs1_data_o);
        wb_we_i = 1'b0;
        apply({7'h00, 5'd5, 5'd9, 3'd0, 5'd1, 7'h33}, 32'h0000_0208);
        val        = $random(seed);
        wb_we_i    = 1'b1;
        wb_waddr_i = 5'd9;  // Same cycle as the rs1 read
        wb_wdata_i = val;
        #1;
        check_val("forward rs1_data_o", val, rs1_data_o);
        check_val("rs2_data_o", shadow[5], rs2_data_o);
        wb_we_i = 1'b0;
        end_test();

        begin_test("stall_clear");
        gen_legal(5, held);
        apply(held, 32'h0000_1000);
        stall_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            gen_legal(i, instr);
            apply(instr, 32'h0000_2000);
            compare_outputs(held, 32'h0000_1000);
        end
        stall_i = 1'b0;
        clear_i = 1'b1;
        apply(instr, 32'h0000_3000);
        compare_outputs(id_pkg::NOP_INSTR, 32'h0);
        clear_i = 1'b0;
        end_test();

        begin_test("jal");
        for (int i = 0; i < 20; i++) begin
            gen_legal(2, instr);
            pc = $random(seed);
            pc[1:0] = 2'b00;
            apply(instr, pc);
            val = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            check_val("jump_o", 32'd1, 32'(jump_o));
            check_val("jump_target_o", pc + val, jump_target_o);
            check_val("imm_o", 32'd4, imm_o);
            check_val("wb_sel_o", 32'(id_pkg::WB_ALU), 32'(wb_sel_o));
            compare_outputs(instr, pc);
        end
        end_test();

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
